//--- source/execute_pkg.sv
package execute_pkg;

  localparam int xlen = 32;

  // iterations of the shared restoring divider, one quotient bit each
  localparam int div_cycles = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] op_t;

  localparam op_t op_nop = 5'd0;
  localparam op_t op_add = 5'd1;
  localparam op_t op_sub = 5'd2;
  localparam op_t op_and = 5'd3;
  localparam op_t op_or = 5'd4;
  localparam op_t op_xor = 5'd5;
  localparam op_t op_sll = 5'd6;
  localparam op_t op_srl = 5'd7;
  localparam op_t op_sra = 5'd8;
  localparam op_t op_slt = 5'd9;
  localparam op_t op_sltu = 5'd10;
  localparam op_t op_lui = 5'd11;

  // control transfers, the target is always pc + imm
  localparam op_t op_beq = 5'd12;
  localparam op_t op_bne = 5'd13;
  localparam op_t op_blt = 5'd14;
  localparam op_t op_bge = 5'd15;
  localparam op_t op_jal = 5'd16;

  // served by the shared divider and never by a lane ALU
  localparam op_t op_div = 5'd17;
  localparam op_t op_divu = 5'd18;
  localparam op_t op_rem = 5'd19;
  localparam op_t op_remu = 5'd20;

  typedef struct packed {
    logic valid;
    op_t op;
    word_t pc;
    word_t rdata1;
    word_t rdata2;
    word_t imm;
    logic use_imm;
  } lane_in_t;

  typedef struct packed {
    word_t result;
    logic taken;
  } alu_out_t;

  typedef struct packed {
    op_t op;
    word_t dividend;
    word_t divisor;
  } div_req_t;

  typedef struct packed {
    logic valid;
    word_t wdata;
    logic jump;
    word_t target;
  } lane_out_t;

  typedef struct packed {
    lane_out_t lane0;
    lane_out_t lane1;
  } retire_pair_t;

  // lane0 is the older instruction of the pair
  typedef struct packed {
    lane_in_t lane0;
    lane_in_t lane1;
  } issue_pair_t;

  typedef enum logic [1:0] {
    div_idle,
    div_run,
    div_done
  } div_state_t;

  typedef enum logic [1:0] {
    req_idle,
    req_wait,
    req_release
  } req_state_t;

endpackage

//--- source/int_alu.sv
`timescale 1ns/1ps

module int_alu (
  input execute_pkg::lane_in_t lane,
  output execute_pkg::alu_out_t alu_out
);

  execute_pkg::word_t operand_a;
  execute_pkg::word_t operand_b;
  logic [4:0] shamt;

  assign operand_a = lane.rdata1;
  assign operand_b = lane.use_imm ? lane.imm : lane.rdata2;
  assign shamt = operand_b[4:0];

  always_comb begin
    alu_out.result = '0;
    alu_out.taken = 1'b0;
    case (lane.op)
      execute_pkg::op_add: begin
        alu_out.result = operand_a + operand_b;
      end
      execute_pkg::op_sub: begin
        alu_out.result = operand_a - operand_b;
      end
      execute_pkg::op_and: begin
        alu_out.result = operand_a & operand_b;
      end
      execute_pkg::op_or: begin
        alu_out.result = operand_a | operand_b;
      end
      execute_pkg::op_xor: begin
        alu_out.result = operand_a ^ operand_b;
      end
      execute_pkg::op_sll: begin
        alu_out.result = operand_a << shamt;
      end
      execute_pkg::op_srl: begin
        alu_out.result = operand_a >> shamt;
      end
      execute_pkg::op_sra: begin
        alu_out.result = $signed(operand_a) >>> shamt;
      end
      execute_pkg::op_slt: begin
        alu_out.result = ($signed(operand_a) < $signed(operand_b)) ? 32'd1 : 32'd0;
      end
      execute_pkg::op_sltu: begin
        alu_out.result = (operand_a < operand_b) ? 32'd1 : 32'd0;
      end
      execute_pkg::op_lui: begin
        alu_out.result = lane.imm;
      end
      // branches always compare the two register operands
      execute_pkg::op_beq: begin
        alu_out.taken = lane.rdata1 == lane.rdata2;
      end
      execute_pkg::op_bne: begin
        alu_out.taken = lane.rdata1 != lane.rdata2;
      end
      execute_pkg::op_blt: begin
        alu_out.taken = $signed(lane.rdata1) < $signed(lane.rdata2);
      end
      execute_pkg::op_bge: begin
        alu_out.taken = $signed(lane.rdata1) >= $signed(lane.rdata2);
      end
      execute_pkg::op_jal: begin
        // link address
        alu_out.result = lane.pc + 32'd4;
        alu_out.taken = 1'b1;
      end
      default: begin
        alu_out.result = '0;
      end
    endcase
  end

endmodule

//--- source/serial_divider.sv
`timescale 1ns/1ps

module serial_divider (
  input logic clock,
  input logic reset,
  input execute_pkg::div_req_t div_req,
  input logic div_valid_req,
  output logic div_ack,
  output execute_pkg::word_t div_result
);

  execute_pkg::div_state_t state;
  logic [$clog2(execute_pkg::div_cycles)-1:0] count;

  execute_pkg::word_t quotient;
  execute_pkg::word_t remainder;
  execute_pkg::word_t divisor;
  execute_pkg::word_t dividend;
  logic want_rem;
  logic neg_q;
  logic neg_r;
  logic by_zero;

  logic is_signed;
  logic sign_a;
  logic sign_b;
  logic [32:0] partial;
  logic [32:0] difference;

  assign is_signed = (div_req.op == execute_pkg::op_div) || (div_req.op == execute_pkg::op_rem);
  assign sign_a = is_signed & div_req.dividend[31];
  assign sign_b = is_signed & div_req.divisor[31];

  // one restoring step: shift in the next dividend bit, then try to subtract
  assign partial = {remainder, quotient[31]};
  assign difference = partial - {1'b0, divisor};

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= execute_pkg::div_idle;
    end else begin
      case (state)
        execute_pkg::div_idle: begin
          if (div_valid_req) begin
            state <= execute_pkg::div_run;
          end
        end
        execute_pkg::div_run: begin
          if (count == '0) begin
            state <= execute_pkg::div_done;
          end
        end
        execute_pkg::div_done: begin
          if (!div_valid_req) begin
            state <= execute_pkg::div_idle;
          end
        end
        default: begin
          state <= execute_pkg::div_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == execute_pkg::div_idle) begin
      count <= $bits(count)'(execute_pkg::div_cycles - 1);
      quotient <= sign_a ? -div_req.dividend : div_req.dividend;
      remainder <= '0;
      divisor <= sign_b ? -div_req.divisor : div_req.divisor;
      dividend <= div_req.dividend;
      want_rem <= (div_req.op == execute_pkg::op_rem) || (div_req.op == execute_pkg::op_remu);
      neg_q <= sign_a ^ sign_b;
      neg_r <= sign_a;
      by_zero <= div_req.divisor == '0;
    end else if (state == execute_pkg::div_run) begin
      count <= count - 1'b1;
      if (!difference[32]) begin
        remainder <= difference[31:0];
        quotient <= {quotient[30:0], 1'b1};
      end else begin
        remainder <= partial[31:0];
        quotient <= {quotient[30:0], 1'b0};
      end
    end
  end

  // most negative by -1 falls out of the magnitude path with no special case
  always_comb begin
    if (by_zero) begin
      div_result = want_rem ? dividend : '1;
    end else if (want_rem) begin
      div_result = neg_r ? -remainder : remainder;
    end else begin
      div_result = neg_q ? -quotient : quotient;
    end
  end

  assign div_ack = state == execute_pkg::div_done;

  a_req_stable: assert property (@(posedge clock) disable iff (!reset)
    (div_valid_req && !div_ack) |=> (!div_valid_req || $stable(div_req)));

endmodule

//--- source/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input logic clock,
  input logic reset,
  input execute_pkg::issue_pair_t issue,
  input logic hold,
  input execute_pkg::alu_out_t alu0_out,
  input execute_pkg::alu_out_t alu1_out,
  input logic div_ack,
  input execute_pkg::word_t div_result,
  output execute_pkg::lane_in_t alu0_in,
  output execute_pkg::lane_in_t alu1_in,
  output execute_pkg::div_req_t div_req,
  output logic div_valid_req,
  output execute_pkg::retire_pair_t retire,
  output logic stall
);

  execute_pkg::req_state_t state;
  execute_pkg::word_t div_data;
  execute_pkg::retire_pair_t next_pair;

  logic squash;
  logic div0;
  logic div1;
  logic has_div;

  function automatic logic is_div(input execute_pkg::op_t op);
    return (op == execute_pkg::op_div) || (op == execute_pkg::op_divu) ||
           (op == execute_pkg::op_rem) || (op == execute_pkg::op_remu);
  endfunction

  assign alu0_in = issue.lane0;
  assign alu1_in = issue.lane1;

  // a taken transfer in lane 0 kills the younger instruction in lane 1
  assign squash = issue.lane0.valid & alu0_out.taken;

  assign div0 = issue.lane0.valid & is_div(issue.lane0.op);
  assign div1 = issue.lane1.valid & ~squash & is_div(issue.lane1.op);
  assign has_div = div0 | div1;

  // the pair waits until the divider result sits in div_data
  assign stall = has_div & (state != execute_pkg::req_release);
  assign div_valid_req = state == execute_pkg::req_wait;

  always_comb begin
    if (div0) begin
      div_req.op = issue.lane0.op;
      div_req.dividend = issue.lane0.rdata1;
      div_req.divisor = issue.lane0.rdata2;
    end else begin
      div_req.op = issue.lane1.op;
      div_req.dividend = issue.lane1.rdata1;
      div_req.divisor = issue.lane1.rdata2;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= execute_pkg::req_idle;
    end else begin
      case (state)
        execute_pkg::req_idle: begin
          // the previous handshake has to be fully closed first
          if (has_div && !div_ack) begin
            state <= execute_pkg::req_wait;
          end
        end
        execute_pkg::req_wait: begin
          if (div_ack) begin
            state <= execute_pkg::req_release;
          end
        end
        execute_pkg::req_release: begin
          if (!hold) begin
            state <= execute_pkg::req_idle;
          end
        end
        default: begin
          state <= execute_pkg::req_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == execute_pkg::req_wait && div_ack) begin
      div_data <= div_result;
    end
  end

  always_comb begin
    next_pair.lane0.valid = issue.lane0.valid;
    next_pair.lane0.wdata = div0 ? div_data : alu0_out.result;
    next_pair.lane0.jump = squash;
    next_pair.lane0.target = issue.lane0.pc + issue.lane0.imm;

    next_pair.lane1.valid = issue.lane1.valid & ~squash;
    next_pair.lane1.wdata = div1 ? div_data : alu1_out.result;
    next_pair.lane1.jump = issue.lane1.valid & ~squash & alu1_out.taken;
    next_pair.lane1.target = issue.lane1.pc + issue.lane1.imm;

    // a stalled cycle retires a bubble
    if (stall) begin
      next_pair.lane0.valid = 1'b0;
      next_pair.lane0.jump = 1'b0;
      next_pair.lane1.valid = 1'b0;
      next_pair.lane1.jump = 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      retire.lane0.valid <= 1'b0;
      retire.lane1.valid <= 1'b0;
    end else if (!hold) begin
      retire <= next_pair;
    end
  end

  a_one_div: assert property (@(posedge clock) disable iff (!reset)
    !(issue.lane0.valid && is_div(issue.lane0.op) &&
      issue.lane1.valid && is_div(issue.lane1.op)));

  a_req_after_ack: assert property (@(posedge clock) disable iff (!reset)
    $rose(div_valid_req) |-> !div_ack);

endmodule

//--- source/dual_execute.sv
`timescale 1ns/1ps

module dual_execute (
  input logic clock,
  input logic reset,
  input execute_pkg::issue_pair_t issue,
  input logic hold,
  output execute_pkg::retire_pair_t retire,
  output logic stall
);

  execute_pkg::lane_in_t alu0_in;
  execute_pkg::lane_in_t alu1_in;
  execute_pkg::alu_out_t alu0_out;
  execute_pkg::alu_out_t alu1_out;
  execute_pkg::div_req_t div_req;
  execute_pkg::word_t div_result;
  logic div_valid_req;
  logic div_ack;

  int_alu u_alu0 (.lane(alu0_in), .alu_out(alu0_out));

  int_alu u_alu1 (.lane(alu1_in), .alu_out(alu1_out));

  // one divider is shared, the stage steers whichever lane holds the division
  serial_divider u_divider (
    .clock(clock),
    .reset(reset),
    .div_req(div_req),
    .div_valid_req(div_valid_req),
    .div_ack(div_ack),
    .div_result(div_result)
  );

  execute_stage u_stage (
    .clock(clock),
    .reset(reset),
    .issue(issue),
    .hold(hold),
    .alu0_out(alu0_out),
    .alu1_out(alu1_out),
    .div_ack(div_ack),
    .div_result(div_result),
    .alu0_in(alu0_in),
    .alu1_in(alu1_in),
    .div_req(div_req),
    .div_valid_req(div_valid_req),
    .retire(retire),
    .stall(stall)
  );

endmodule

//--- tb/dual_execute_tb.sv
`timescale 1ns/1ps

module dual_execute_tb;

  logic clock;
  logic reset;
  logic hold;
  logic stall;
  execute_pkg::issue_pair_t issue;
  execute_pkg::retire_pair_t retire;

  execute_pkg::issue_pair_t vec_issue[$];
  execute_pkg::retire_pair_t vec_expect[$];
  int errors;
  int checked;
  longint timeout_ns;

  dual_execute u_dut (
    .clock(clock),
    .reset(reset),
    .issue(issue),
    .hold(hold),
    .retire(retire),
    .stall(stall)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #2 clock = ~clock;
    end
  end

  function automatic execute_pkg::lane_in_t lane_from_fields(
      input execute_pkg::word_t f [0:21], input int base);
    execute_pkg::lane_in_t lane;
    lane.valid = f[base][0];
    lane.op = f[base+1][4:0];
    lane.pc = f[base+2];
    lane.rdata1 = f[base+3];
    lane.rdata2 = f[base+4];
    lane.imm = f[base+5];
    lane.use_imm = f[base+6][0];
    return lane;
  endfunction

  function automatic execute_pkg::lane_out_t result_from_fields(
      input execute_pkg::word_t f [0:21], input int base);
    execute_pkg::lane_out_t lane;
    lane.valid = f[base][0];
    lane.wdata = f[base+1];
    lane.jump = f[base+2][0];
    lane.target = f[base+3];
    return lane;
  endfunction

  task automatic load_vectors();
    int fd;
    int count;
    string line;
    execute_pkg::word_t f [0:21];
    execute_pkg::issue_pair_t pair;
    execute_pkg::retire_pair_t expected;
    fd = $fopen("tb/execute_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file tb/execute_stim.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      count = $fgets(line, fd);
      if (count == 0) break;
      // blank lines and comment lines carry no vector
      if (line.len() < 2 || line[0] == "#") continue;
      count = $sscanf(line,
        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
        f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21]);
      if (count != 22) begin
        $display("malformed stimulus line, only %0d fields read: %s", count, line);
        errors++;
      end else begin
        pair.lane0 = lane_from_fields(f, 0);
        pair.lane1 = lane_from_fields(f, 7);
        expected.lane0 = result_from_fields(f, 14);
        expected.lane1 = result_from_fields(f, 18);
        vec_issue.push_back(pair);
        vec_expect.push_back(expected);
      end
    end
    $fclose(fd);
  endtask

  task automatic compare_word(input string name, input execute_pkg::word_t expected,
      input execute_pkg::word_t actual);
    assert (actual === expected) else begin
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic verify_lane(input string name, input execute_pkg::op_t op,
      input execute_pkg::lane_out_t expected, input execute_pkg::lane_out_t actual);
    logic branch;
    branch = (op >= execute_pkg::op_beq) && (op <= execute_pkg::op_bge);
    compare_word({name, ".valid"}, 32'(expected.valid), 32'(actual.valid));
    compare_word({name, ".jump"}, 32'(expected.jump), 32'(actual.jump));
    // a branch writes no register, so its wdata means nothing
    if (expected.valid && !branch) begin
      compare_word({name, ".wdata"}, expected.wdata, actual.wdata);
    end
    if (expected.jump) begin
      compare_word({name, ".target"}, expected.target, actual.target);
    end
  endtask

  task automatic expect_bubble();
    compare_word("retire.lane0.valid", 32'd0, 32'(retire.lane0.valid));
    compare_word("retire.lane1.valid", 32'd0, 32'(retire.lane1.valid));
  endtask

  function automatic logic divider_op(input execute_pkg::op_t op);
    return (op >= execute_pkg::op_div) && (op <= execute_pkg::op_remu);
  endfunction

  // a squashed lane 1 never reaches the divider
  function automatic logic stalls_for_division(input int idx);
    return (vec_issue[idx].lane0.valid && divider_op(vec_issue[idx].lane0.op)) ||
           (vec_expect[idx].lane1.valid && divider_op(vec_issue[idx].lane1.op));
  endfunction

  initial begin
    int idx;
    int pending;
    int shown;
    logic accepted;
    logic last_hold;
    logic stall_seen;
    execute_pkg::issue_pair_t reset_pair;
    errors = 0;
    checked = 0;
    timeout_ns = 0;
    // valid lanes during reset would reach retire if reset did not clear it
    reset_pair = '0;
    reset_pair.lane0.valid = 1'b1;
    reset_pair.lane1.valid = 1'b1;
    reset <= 1'b0;
    hold <= 1'b0;
    issue <= reset_pair;
    void'($urandom(32'h62f4));
    load_vectors();
    if (vec_issue.size() > 0) begin
      timeout_ns = longint'(vec_issue.size()) * (execute_pkg::div_cycles + 10) * 4 * 2;
    end
    repeat (3) @(posedge clock);
    reset <= 1'b1;
    issue <= '0;
    @(negedge clock);
    expect_bubble();
    compare_word("stall", 32'd0, 32'(stall));
    idx = 0;
    pending = -1;
    shown = -1;
    last_hold = 1'b0;
    stall_seen = 1'b0;
    if (vec_issue.size() > 0) begin
      @(posedge clock);
      issue <= vec_issue[0];
      hold <= ($urandom % 4) == 0;
      while (checked < vec_issue.size()) begin
        @(negedge clock);
        // retire shows what the last rising edge loaded and keeps it under hold
        if (pending >= 0) begin
          shown = pending;
          checked++;
        end else if (!last_hold) begin
          shown = -1;
        end
        if (shown >= 0) begin
          verify_lane("retire.lane0", vec_issue[shown].lane0.op,
            vec_expect[shown].lane0, retire.lane0);
          verify_lane("retire.lane1", vec_issue[shown].lane1.op,
            vec_expect[shown].lane1, retire.lane1);
        end else begin
          expect_bubble();
        end
        if (stall) begin
          stall_seen = 1'b1;
        end
        accepted = (idx < vec_issue.size()) && !stall && !hold;
        if (accepted) begin
          compare_word("stall", 32'(stalls_for_division(idx)), 32'(stall_seen));
        end
        last_hold = hold;
        @(posedge clock);
        pending = -1;
        if (accepted) begin
          pending = idx;
          idx++;
          stall_seen = 1'b0;
          issue <= (idx < vec_issue.size()) ? vec_issue[idx] : '0;
        end
        hold <= ($urandom % 4) == 0;
      end
    end
    $display("%0d errors, %0d of %0d vectors checked", errors, checked, vec_issue.size());
    if (errors == 0 && checked > 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    wait (timeout_ns != 0);
    #(timeout_ns);
    $display("timeout after %0d ns, the DUT stopped accepting or retiring pairs", timeout_ns);
    $display("Test failed");
    $finish;
  end

endmodule

//--- tb/execute_stim.txt
# lane0 then lane1, each: valid op pc rdata1 rdata2 imm use_imm (all hex)
# then expected retire lane0 and lane1, each: valid wdata jump target (all hex)
1 01 100 5 7 0 0  1 02 104 a 3 0 0  1 c 0 0  1 7 0 0
1 03 108 f0f0 ff00 0 0  1 04 10c 12 0 f00 1  1 f000 0 0  1 f12 0 0
1 05 110 ffff0000 0ff00ff0 0 0  1 06 114 1 0 1f 1  1 f00f0ff0 0 0  1 80000000 0 0
1 07 118 80000000 24 0 0  1 08 11c 80000000 4 0 0  1 8000000 0 0  1 f8000000 0 0
1 09 120 ffffffff 1 0 0  1 0a 124 ffffffff 1 0 0  1 1 0 0  1 0 0 0
1 0b 128 0 0 12345000 1  1 01 12c 10 0 fffffff0 1  1 12345000 0 0  1 0 0 0
1 09 130 5 0 fffffffb 1  1 0a 134 5 0 fffffffb 1  1 0 0 0  1 1 0 0
1 0c 200 7 7 40 0  1 01 204 1 2 0 0  1 0 1 240  0 0 0 0
1 0d 240 7 7 20 0  1 01 244 1 2 0 0  1 0 0 0  1 3 0 0
1 0e 300 fffffffe 1 fffffff8 0  1 02 304 5 1 0 0  1 0 1 2f8  0 0 0 0
1 0f 400 fffffffe 1 10 0  1 0e 404 1 2 10 0  1 0 0 0  1 0 1 414
1 10 500 0 0 100 0  1 02 504 9 3 0 0  1 504 1 600  0 0 0 0
1 01 600 3 4 0 0  1 10 604 0 0 fffffffc 0  1 7 0 0  1 608 1 600
1 11 700 ffffffec 3 0 0  1 01 704 2 2 0 0  1 fffffffa 0 0  1 4 0 0
1 05 708 3 5 0 0  1 13 70c ffffffec 3 0 0  1 6 0 0  1 fffffffe 0 0
1 12 710 ffffffec 3 0 0  1 04 714 a 5 0 0  1 5555554e 0 0  1 f 0 0
1 06 718 3 2 0 0  1 14 71c ffffffec 3 0 0  1 c 0 0  1 2 0 0
1 11 720 1234 0 0 0  1 01 724 1 1 0 0  1 ffffffff 0 0  1 2 0 0
1 03 728 ff f 0 0  1 13 72c 1234 0 0 0  1 f 0 0  1 1234 0 0
1 12 730 1234 0 0 0  1 02 734 10 1 0 0  1 ffffffff 0 0  1 f 0 0
1 11 738 80000000 ffffffff 0 0  1 01 73c 7 8 0 0  1 80000000 0 0  1 f 0 0
1 04 740 f0 f 0 0  1 13 744 80000000 ffffffff 0 0  1 ff 0 0  1 0 0 0
1 11 748 7 fffffffe 0 0  1 03 74c c a 0 0  1 fffffffd 0 0  1 8 0 0
1 0b 750 0 0 abcde000 1  1 13 754 7 fffffffe 0 0  1 abcde000 0 0  1 1 0 0
1 10 800 0 0 20 0  1 11 804 64 5 0 0  1 804 1 820  0 0 0 0
1 01 820 ffffffff 1 0 0  0 01 824 1 1 0 0  1 0 0 0  0 0 0 0

//--- dual_execute.f
source/execute_pkg.sv
source/int_alu.sv
source/serial_divider.sv
source/execute_stage.sv
source/dual_execute.sv
tb/dual_execute_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f dual_execute.f --top-module dual_execute_tb \
  -Mdir "$build_dir" -o dual_execute_sim

"./$build_dir/dual_execute_sim" 2>&1 | tee "$log_file"

if grep -q "Test completed successfully" "$log_file"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see $log_file"
  exit 1
fi
